/* flist.f */
+incdir+common
common/isa_pkg.sv
common/ooo_pkg.sv
common/exec_if.sv
rob/reorder_buffer.sv
design/cdb_arbiter.sv
design/alu_unit.sv
design/branch_unit.sv
design/ooo_backend_top.sv
bench/tb_ooo_backend.sv

/* Makefile */
# Verilator simulation of the out-of-order back end

VERILATOR ?= verilator
TOP       ?= tb_ooo_backend
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_ooo_backend.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module tb_ooo_backend;
    // cycles any single wait may take
    localparam int TIMEOUT = 300;

    logic              clk;
    logic              rst_n;
    logic              dispatch_valid;
    isa_pkg::opcode_e  dispatch_op;
    isa_pkg::reg_idx_t dispatch_rd;
    logic [`XLEN-1:0]  dispatch_a;
    logic [`XLEN-1:0]  dispatch_b;
    logic [`XLEN-1:0]  dispatch_pc;
    logic [`XLEN-1:0]  dispatch_imm;
    logic              rob_full;
    logic              rob_empty;
    logic              commit_valid;
    isa_pkg::reg_idx_t commit_rd;
    logic [`XLEN-1:0]  commit_value;
    logic              redirect_valid;
    logic [`XLEN-1:0]  redirect_pc;

    // predicted commits, program order
    isa_pkg::reg_idx_t exp_rd  [$];
    logic [`XLEN-1:0]  exp_val [$];
    logic [`XLEN-1:0]  exp_pc  [$];
    // observed commits and redirects
    isa_pkg::reg_idx_t got_rd  [$];
    logic [`XLEN-1:0]  got_val [$];
    logic [`XLEN-1:0]  got_pc  [$];

    int          mismatch_count;
    int          fail_count;
    int          total_expected;
    int          total_commits = 0;
    int          redirect_cnt = 0;
    // redirect count when the last taken branch was predicted
    int          wp_mark;
    // set between a predicted taken branch and its redirect
    logic        wrong_path;
    logic [31:0] lfsr;

    ooo_backend_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_pc    (dispatch_pc),
        .dispatch_imm   (dispatch_imm),
        .rob_full       (rob_full),
        .rob_empty      (rob_empty),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // sample strobes mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (commit_valid) begin
                got_rd.push_back(commit_rd);
                got_val.push_back(commit_value);
                total_commits++;
            end
            if (redirect_valid) begin
                got_pc.push_back(redirect_pc);
                redirect_cnt++;
                // whole buffer cleared at the redirect edge
                if (rob_empty !== 1'b1) begin
                    fail_count++;
                    $display("rob_empty is not high in the cycle after a redirect");
                end
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic is_branch(input isa_pkg::opcode_e op);
        return (op == isa_pkg::op_beq) || (op == isa_pkg::op_bne);
    endfunction

    // RV32I semantics
    function automatic logic [`XLEN-1:0] alu_model(input isa_pkg::opcode_e op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        case (op)
            isa_pkg::op_add: return a + b;
            isa_pkg::op_sub: return a - b;
            isa_pkg::op_and: return a & b;
            isa_pkg::op_or:  return a | b;
            isa_pkg::op_xor: return a ^ b;
            // shamt is b[4:0]
            isa_pkg::op_sll: return a << b[4:0];
            isa_pkg::op_slt: return ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
            default:         return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input isa_pkg::opcode_e op,
                                          input logic [`XLEN-1:0] a,
                                          input logic [`XLEN-1:0] b);
        return (op == isa_pkg::op_beq) ? (a == b) : (a != b);
    endfunction

    task automatic fail_on_timeout(input string what);
        fail_count++;
        $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    // wrong path ops never enter the expected list
    task automatic predict(input isa_pkg::opcode_e op, input isa_pkg::reg_idx_t rd,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                           input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] imm);
        if (!wrong_path) begin
            total_expected++;
            if (is_branch(op)) begin
                // branch retires as a write to x0
                exp_rd.push_back('0);
                exp_val.push_back('0);
                if (branch_taken(op, a, b)) begin
                    exp_pc.push_back(pc + imm);
                    wrong_path = 1'b1;
                    wp_mark    = redirect_cnt;
                end
            end else begin
                exp_rd.push_back(rd);
                exp_val.push_back(alu_model(op, a, b));
            end
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic send_op(input isa_pkg::opcode_e op, input isa_pkg::reg_idx_t rd,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                           input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] imm);
        int waited;
        waited = 0;
        while (rob_full) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                fail_on_timeout("rob_full to drop");
            end
        end
        // redirect seen, front end back on the right path
        if (wrong_path && (redirect_valid || redirect_cnt != wp_mark)) begin
            wrong_path = 1'b0;
        end
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_rd    = rd;
        dispatch_a     = a;
        dispatch_b     = b;
        dispatch_pc    = pc;
        dispatch_imm   = imm;
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        predict(op, rd, a, b, pc, imm);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!rob_empty) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                fail_on_timeout("rob_empty");
            end
        end
        // quiet cycles, stray commits would land here
        repeat (4) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_commit(input isa_pkg::reg_idx_t want_rd, input isa_pkg::reg_idx_t rd,
                                input logic [`XLEN-1:0] want_val, input logic [`XLEN-1:0] val);
        if (rd !== want_rd || val !== want_val) begin
            mismatch_count++;
            $display("Mismatch at %0t: commit rd %0d value %h, expected rd %0d value %h",
                     $time, rd, val, want_rd, want_val);
        end
    endtask

    task automatic check_redirect(input logic [`XLEN-1:0] want_pc, input logic [`XLEN-1:0] pc);
        if (pc !== want_pc) begin
            mismatch_count++;
            $display("Mismatch at %0t: redirect pc %h, expected %h", $time, pc, want_pc);
        end
    endtask

    task automatic compare_results(input string name);
        while (exp_rd.size() > 0 && got_rd.size() > 0) begin
            check_commit(exp_rd.pop_front(), got_rd.pop_front(),
                         exp_val.pop_front(), got_val.pop_front());
        end
        while (exp_pc.size() > 0 && got_pc.size() > 0) begin
            check_redirect(exp_pc.pop_front(), got_pc.pop_front());
        end
        if (got_rd.size() > 0) begin
            fail_count++;
            $display("%s: %0d commits that no dispatch predicted", name, got_rd.size());
        end
        if (exp_rd.size() > 0) begin
            fail_count++;
            $display("%s: %0d predicted commits never happened", name, exp_rd.size());
        end
        if (got_pc.size() > 0) begin
            fail_count++;
            $display("%s: %0d redirects that were not expected", name, got_pc.size());
        end
        if (exp_pc.size() > 0) begin
            fail_count++;
            $display("%s: %0d expected redirects never happened", name, exp_pc.size());
        end
        exp_rd.delete();
        exp_val.delete();
        exp_pc.delete();
        got_rd.delete();
        got_val.delete();
        got_pc.delete();
    endtask

    task automatic check_reset_state();
        if (rob_empty !== 1'b1) begin
            fail_count++;
            $display("rob_empty is not high after reset");
        end
        if (rob_full !== 1'b0) begin
            fail_count++;
            $display("rob_full is not low after reset");
        end
        if (commit_valid !== 1'b0 || redirect_valid !== 1'b0) begin
            fail_count++;
            $display("commit or redirect strobe is not low after reset");
        end
    endtask

    task automatic run_alu_corners();
        // signed overflow wraps, carry out dropped
        send_op(isa_pkg::op_add, 5'd1, 32'h7fff_ffff, 32'h0000_0001, '0, '0);
        send_op(isa_pkg::op_add, 5'd2, 32'hffff_ffff, 32'h0000_0001, '0, '0);
        send_op(isa_pkg::op_sub, 5'd3, 32'h0000_0000, 32'h0000_0001, '0, '0);
        send_op(isa_pkg::op_and, 5'd4, 32'hf0f0_f0f0, 32'hff00_ff00, '0, '0);
        send_op(isa_pkg::op_or,  5'd5, 32'hf0f0_f0f0, 32'h0f00_000f, '0, '0);
        send_op(isa_pkg::op_xor, 5'd6, 32'ha5a5_a5a5, 32'hffff_ffff, '0, '0);
        send_op(isa_pkg::op_sll, 5'd7, 32'h0000_0001, 32'd31, '0, '0);
        // upper bits of b ignored
        send_op(isa_pkg::op_sll, 5'd8, 32'h0000_0003, 32'h0000_0021, '0, '0);
        send_op(isa_pkg::op_slt, 5'd9, 32'hffff_ffff, 32'h0000_0001, '0, '0);
        send_op(isa_pkg::op_slt, 5'd10, 32'h0000_0001, 32'hffff_ffff, '0, '0);
        send_op(isa_pkg::op_slt, 5'd11, 32'h8000_0000, 32'h7fff_ffff, '0, '0);
        send_op(isa_pkg::op_slt, 5'd12, 32'd5, 32'd5, '0, '0);
        wait_idle();
        compare_results("alu corners");
    endtask

    // branches finish first and fight the ALU for the CDB
    task automatic burst_in_order();
        send_op(isa_pkg::op_add, 5'd1, 32'd10, 32'd20, '0, '0);
        send_op(isa_pkg::op_beq, 5'd9, 32'd1, 32'd2, 32'h200, 32'h10);
        send_op(isa_pkg::op_sub, 5'd2, 32'd7, 32'd9, '0, '0);
        send_op(isa_pkg::op_bne, 5'd9, 32'd4, 32'd4, 32'h204, 32'h20);
        send_op(isa_pkg::op_slt, 5'd3, 32'hffff_fff0, 32'd3, '0, '0);
        send_op(isa_pkg::op_beq, 5'd9, 32'd0, 32'd5, 32'h208, 32'h30);
        send_op(isa_pkg::op_xor, 5'd4, 32'h1234_5678, 32'h0f0f_0f0f, '0, '0);
        send_op(isa_pkg::op_or,  5'd5, 32'h8000_0000, 32'h1, '0, '0);
        send_op(isa_pkg::op_bne, 5'd9, 32'hdead, 32'hdead, 32'h20c, 32'h40);
        send_op(isa_pkg::op_sll, 5'd6, 32'h0000_00ff, 32'd8, '0, '0);
        send_op(isa_pkg::op_and, 5'd7, 32'hffff_0000, 32'h0ff0_0ff0, '0, '0);
        send_op(isa_pkg::op_beq, 5'd9, 32'd3, 32'd4, 32'h210, 32'h50);
        wait_idle();
        compare_results("ordered burst");
    endtask

    task automatic taken_branch_flush();
        send_op(isa_pkg::op_add, 5'd1, 32'd1, 32'd2, '0, '0);
        // taken, target 0x140
        send_op(isa_pkg::op_beq, 5'd0, 32'd77, 32'd77, 32'h100, 32'h40);
        send_op(isa_pkg::op_sub, 5'd2, 32'd50, 32'd8, '0, '0);
        send_op(isa_pkg::op_or,  5'd3, 32'h0f, 32'hf0, '0, '0);
        send_op(isa_pkg::op_xor, 5'd4, 32'h55, 32'haa, '0, '0);
        wait_idle();
        compare_results("taken branch");
    endtask

    // nine ops in a row, tags wrap past slot 0
    task automatic refill_after_flush();
        for (int i = 0; i < 9; i++) begin
            send_op(isa_pkg::op_add, isa_pkg::reg_idx_t'(i + 1), 32'(i * 3), 32'd100, '0, '0);
        end
        send_op(isa_pkg::op_bne, 5'd0, 32'd6, 32'd6, 32'h300, 32'h8);
        send_op(isa_pkg::op_sub, 5'd20, 32'd1, 32'd3, '0, '0);
        wait_idle();
        compare_results("after flush");
    endtask

    task automatic random_stream(input int n);
        logic [31:0]       r;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  imm;
        isa_pkg::opcode_e  op;
        isa_pkg::reg_idx_t rd;
        for (int i = 0; i < n; i++) begin
            take_bits(4, r);
            op = isa_pkg::opcode_e'(r[3:0] % 4'd9);
            take_bits(5, r);
            rd = r[4:0];
            take_bits(32, a);
            take_bits(32, b);
            // equal operands now and then so beq can be taken
            take_bits(2, r);
            if (r[1:0] == 2'b00) begin
                b = a;
            end
            take_bits(30, r);
            pc = {r[29:0], 2'b00};
            take_bits(12, r);
            imm = {{20{r[11]}}, r[11:0]};
            send_op(op, rd, a, b, pc, imm);
            // idle gap about one time in four
            take_bits(2, r);
            if (r[1:0] == 2'b00) begin
                @(posedge clk);
                #1;
            end
        end
        wait_idle();
        compare_results("random stream");
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = isa_pkg::op_add;
        dispatch_rd    = '0;
        dispatch_a     = '0;
        dispatch_b     = '0;
        dispatch_pc    = '0;
        dispatch_imm   = '0;
        mismatch_count = 0;
        fail_count     = 0;
        total_expected = 0;
        wp_mark        = 0;
        wrong_path     = 1'b0;
        lfsr           = 32'd86710;

        repeat (4) begin
            @(posedge clk);
        end
        #1;
        rst_n = 1'b1;

        check_reset_state();
        run_alu_corners();
        burst_in_order();
        taken_branch_flush();
        refill_after_flush();
        random_stream(200);

        if (total_commits != total_expected) begin
            fail_count++;
            $display("saw %0d commits but predicted %0d", total_commits, total_expected);
        end
        $display("errors: %0d mismatches, %0d other failures, %0d commits checked",
                 mismatch_count, fail_count, total_commits);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/ooo_backend_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module ooo_backend_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dispatch_valid,
    input  wire isa_pkg::opcode_e   dispatch_op,
    input  wire isa_pkg::reg_idx_t  dispatch_rd,
    input  wire [`XLEN-1:0]         dispatch_a,
    input  wire [`XLEN-1:0]         dispatch_b,
    input  wire [`XLEN-1:0]         dispatch_pc,
    input  wire [`XLEN-1:0]         dispatch_imm,
    output logic                    rob_full,
    output logic                    rob_empty,
    output logic                    commit_valid,
    output isa_pkg::reg_idx_t       commit_rd,
    output logic [`XLEN-1:0]        commit_value,
    output logic                    redirect_valid,
    output logic [`XLEN-1:0]        redirect_pc
);
    // taken branch at commit, clears everything
    logic          flush;
    ooo_pkg::cdb_t cdb;

    // issue paths, one per unit
    exec_issue_if alu_issue_if ();
    exec_issue_if br_issue_if ();
    // requests into the shared bus
    cdb_req_if    alu_cdb_if ();
    cdb_req_if    br_cdb_if ();

    reorder_buffer rob_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_rd    (dispatch_rd),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_pc    (dispatch_pc),
        .dispatch_imm   (dispatch_imm),
        .alu_issue      (alu_issue_if.source),
        .br_issue       (br_issue_if.source),
        .cdb            (cdb),
        .flush          (flush),
        .full           (rob_full),
        .empty          (rob_empty),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    alu_unit alu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .issue   (alu_issue_if.unit),
        .cdb_req (alu_cdb_if.unit)
    );

    branch_unit br_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .issue   (br_issue_if.unit),
        .cdb_req (br_cdb_if.unit)
    );

    cdb_arbiter arb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .alu_req (alu_cdb_if.arbiter),
        .br_req  (br_cdb_if.arbiter),
        .cdb     (cdb)
    );

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module branch_unit (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         flush,
    exec_issue_if.unit  issue,
    cdb_req_if.unit     cdb_req
);
    localparam int unsigned DEPTH = `ROB_ENTRIES - 1;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    logic              taken;
    logic [`XLEN-1:0]  target;
    ooo_pkg::rob_tag_t q_tag    [DEPTH];
    logic              q_taken  [DEPTH];
    logic [`XLEN-1:0]  q_target [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  q_count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    // condition and target straight from issue
    assign taken  = (issue.op == isa_pkg::op_beq) ? (issue.a == issue.b)
                                                  : (issue.a != issue.b);
    assign target = issue.pc + issue.imm;

    // one edge after issue the outcome sits in the queue
    assign push = issue.valid;
    assign pop  = cdb_req.req && cdb_req.grant;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            q_count <= q_count + PTR_W'(push) - PTR_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_tag[wr_ptr]    <= issue.tag;
            q_taken[wr_ptr]  <= taken;
            q_target[wr_ptr] <= target;
        end
    end

    // branches carry no register value
    assign cdb_req.req    = (q_count != '0);
    assign cdb_req.tag    = q_tag[rd_ptr];
    assign cdb_req.value  = '0;
    assign cdb_req.taken  = q_taken[rd_ptr];
    assign cdb_req.target = q_target[rd_ptr];

    // steering in the reorder buffer sends only compares here
    a_branch_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue.valid |-> issue.op inside {isa_pkg::op_beq, isa_pkg::op_bne});

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module alu_unit (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         flush,
    exec_issue_if.unit  issue,
    cdb_req_if.unit     cdb_req
);
    // one slot per usable tag, so no overflow
    localparam int unsigned DEPTH = `ROB_ENTRIES - 1;
    localparam int unsigned PTR_W = $clog2(DEPTH);

    logic              s1_valid;
    ooo_pkg::rob_tag_t s1_tag;
    isa_pkg::opcode_e  s1_op;
    logic [`XLEN-1:0]  s1_a;
    logic [`XLEN-1:0]  s1_b;
    logic [`XLEN-1:0]  s2_result;
    ooo_pkg::rob_tag_t q_tag   [DEPTH];
    logic [`XLEN-1:0]  q_value [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  q_count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    // stage 1 operand capture
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag <= issue.tag;
        s1_op  <= issue.op;
        s1_a   <= issue.a;
        s1_b   <= issue.b;
    end

    // stage 2 compute, result written into the queue at the next edge
    always_comb begin
        case (s1_op)
            isa_pkg::op_add: s2_result = s1_a + s1_b;
            isa_pkg::op_sub: s2_result = s1_a - s1_b;
            isa_pkg::op_and: s2_result = s1_a & s1_b;
            isa_pkg::op_or:  s2_result = s1_a | s1_b;
            isa_pkg::op_xor: s2_result = s1_a ^ s1_b;
            // shift amount is the low five bits
            isa_pkg::op_sll: s2_result = s1_a << s1_b[4:0];
            isa_pkg::op_slt: s2_result = `XLEN'($signed(s1_a) < $signed(s1_b));
            default:         s2_result = '0;
        endcase
    end

    assign push = s1_valid;
    assign pop  = cdb_req.req && cdb_req.grant;

    // result queue pointers
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            q_count <= q_count + PTR_W'(push) - PTR_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_tag[wr_ptr]   <= s1_tag;
            q_value[wr_ptr] <= s2_result;
        end
    end

    // head of queue goes to the arbiter
    assign cdb_req.req    = (q_count != '0);
    assign cdb_req.tag    = q_tag[rd_ptr];
    assign cdb_req.value  = q_value[rd_ptr];
    assign cdb_req.taken  = 1'b0;
    assign cdb_req.target = '0;

    // reorder buffer capacity bounds what is in flight here
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> q_count != PTR_W'(DEPTH));

endmodule

`default_nettype wire

/* design/cdb_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module cdb_arbiter (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            flush,
    cdb_req_if.arbiter     alu_req,
    cdb_req_if.arbiter     br_req,
    output ooo_pkg::cdb_t  cdb
);
    // 0 favours the ALU, 1 the branch unit
    logic prio_br;
    logic contested;

    assign contested = alu_req.req && br_req.req;

    // grant is combinational, unit pops on req and grant at the edge
    assign alu_req.grant = alu_req.req && (!br_req.req || !prio_br);
    assign br_req.grant  = br_req.req && (!alu_req.req || prio_br);

    // flip only when both asked
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            prio_br <= 1'b0;
        end else if (contested) begin
            prio_br <= !prio_br;
        end
    end

    // winner onto the bus
    always_comb begin
        cdb = '0;
        if (alu_req.grant) begin
            cdb.valid  = 1'b1;
            cdb.tag    = alu_req.tag;
            cdb.value  = alu_req.value;
            cdb.taken  = alu_req.taken;
            cdb.target = alu_req.target;
        end else if (br_req.grant) begin
            cdb.valid  = 1'b1;
            cdb.tag    = br_req.tag;
            cdb.value  = br_req.value;
            cdb.taken  = br_req.taken;
            cdb.target = br_req.target;
        end
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst_n) !(alu_req.grant && br_req.grant));

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

module reorder_buffer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     dispatch_valid,
    input  wire isa_pkg::opcode_e   dispatch_op,
    input  wire isa_pkg::reg_idx_t  dispatch_rd,
    input  wire [`XLEN-1:0]         dispatch_a,
    input  wire [`XLEN-1:0]         dispatch_b,
    input  wire [`XLEN-1:0]         dispatch_pc,
    input  wire [`XLEN-1:0]         dispatch_imm,
    exec_issue_if.source            alu_issue,
    exec_issue_if.source            br_issue,
    input  wire ooo_pkg::cdb_t      cdb,
    output logic                    flush,
    output logic                    full,
    output logic                    empty,
    output logic                    commit_valid,
    output isa_pkg::reg_idx_t       commit_rd,
    output logic [`XLEN-1:0]        commit_value,
    output logic                    redirect_valid,
    output logic [`XLEN-1:0]        redirect_pc
);
    localparam int unsigned USABLE = `ROB_ENTRIES - 1;

    ooo_pkg::rob_entry_t   rob_q [`ROB_ENTRIES];
    ooo_pkg::rob_entry_t   head_ent;
    ooo_pkg::rob_tag_t     head;
    ooo_pkg::rob_tag_t     tail;
    logic [`ROB_TAG_W-1:0] count;
    logic                  alloc;
    logic                  is_br;
    logic                  head_fire;
    logic                  head_br;

    // next slot, slot 0 skipped on wrap
    function automatic ooo_pkg::rob_tag_t wrap_inc(input ooo_pkg::rob_tag_t p);
        return (p == ooo_pkg::rob_tag_t'(`ROB_ENTRIES - 1)) ? ooo_pkg::rob_tag_t'(1)
                                                           : p + ooo_pkg::rob_tag_t'(1);
    endfunction

    assign full  = (count == `ROB_TAG_W'(USABLE));
    assign empty = (count == '0);

    // opcode class picks the unit
    assign is_br = dispatch_op inside {isa_pkg::op_beq, isa_pkg::op_bne};
    // a dispatch during flush is younger than the taken branch, drop it
    assign alloc = dispatch_valid && !full && !flush;

    assign head_ent  = rob_q[head];
    assign head_fire = head_ent.valid && head_ent.done;
    assign head_br   = head_ent.op inside {isa_pkg::op_beq, isa_pkg::op_bne};
    // predicted not taken, so a taken branch at the head kills everything younger
    assign flush     = head_fire && head_ent.taken;

    // issue in the dispatch cycle, tag is the slot being written
    assign alu_issue.valid = alloc && !is_br;
    assign alu_issue.tag   = tail;
    assign alu_issue.op    = dispatch_op;
    assign alu_issue.a     = dispatch_a;
    assign alu_issue.b     = dispatch_b;
    assign alu_issue.pc    = dispatch_pc;
    assign alu_issue.imm   = dispatch_imm;

    assign br_issue.valid  = alloc && is_br;
    assign br_issue.tag    = tail;
    assign br_issue.op     = dispatch_op;
    assign br_issue.a      = dispatch_a;
    assign br_issue.b      = dispatch_b;
    assign br_issue.pc     = dispatch_pc;
    assign br_issue.imm    = dispatch_imm;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < `ROB_ENTRIES; i++) begin
                rob_q[i].valid <= 1'b0;
                rob_q[i].done  <= 1'b0;
            end
            // first usable slot
            head  <= ooo_pkg::rob_tag_t'(1);
            tail  <= ooo_pkg::rob_tag_t'(1);
            count <= '0;
        end else begin
            if (alloc) begin
                rob_q[tail].valid <= 1'b1;
                rob_q[tail].done  <= 1'b0;
                rob_q[tail].op    <= dispatch_op;
                rob_q[tail].rd    <= dispatch_rd;
                tail              <= wrap_inc(tail);
            end
            // completion from the CDB
            if (cdb.valid) begin
                rob_q[cdb.tag].done   <= 1'b1;
                rob_q[cdb.tag].value  <= cdb.value;
                rob_q[cdb.tag].taken  <= cdb.taken;
                rob_q[cdb.tag].target <= cdb.target;
            end
            // retire the head in program order
            if (head_fire) begin
                rob_q[head].valid <= 1'b0;
                rob_q[head].done  <= 1'b0;
                head              <= wrap_inc(head);
            end
            count <= count + `ROB_TAG_W'(alloc) - `ROB_TAG_W'(head_fire);
        end
    end

    // commit and redirect strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= head_fire;
            redirect_valid <= flush;
        end
    end

    // branches write no register
    always_ff @(posedge clk) begin
        commit_rd    <= head_br ? isa_pkg::reg_idx_t'(0) : head_ent.rd;
        commit_value <= head_ent.value;
        redirect_pc  <= head_ent.target;
    end

    // source must hold off on rob_full
    a_no_dispatch_full: assert property (
        @(posedge clk) disable iff (!rst_n) dispatch_valid |-> !full);

    // units only broadcast tags they were issued
    a_cdb_tag_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) cdb.valid |-> cdb.tag != '0);

    // one completion per slot, and never after the slot was freed
    a_cdb_tag_live: assert property (
        @(posedge clk) disable iff (!rst_n)
        cdb.valid |-> rob_q[cdb.tag].valid && !rob_q[cdb.tag].done);

endmodule

`default_nettype wire

/* common/exec_if.sv */
`timescale 1ns/1ns
`default_nettype none
`include "rob_macros.svh"

// issue from the reorder buffer to one execution unit
// valid is a one-cycle strobe, no stall
interface exec_issue_if;
    logic              valid;
    ooo_pkg::rob_tag_t tag;
    isa_pkg::opcode_e  op;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  imm;

    modport source (output valid, tag, op, a, b, pc, imm);
    modport unit   (input  valid, tag, op, a, b, pc, imm);
endinterface

// result request from a unit to the CDB arbiter
// req held while the unit's queue holds a result
interface cdb_req_if;
    logic              req;
    logic              grant;
    ooo_pkg::rob_tag_t tag;
    logic [`XLEN-1:0]  value;
    logic              taken;
    logic [`XLEN-1:0]  target;

    modport unit    (output req, tag, value, taken, target, input grant);
    modport arbiter (input  req, tag, value, taken, target, output grant);
endinterface

`default_nettype wire

/* common/ooo_pkg.sv */
`default_nettype none
`include "rob_macros.svh"

package ooo_pkg;

    // reorder buffer tag, 0 means no tag
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // one reorder buffer slot
    typedef struct packed {
        // slot allocated
        logic              valid;
        // result seen on the CDB
        logic              done;
        isa_pkg::opcode_e  op;
        isa_pkg::reg_idx_t rd;
        // ALU result
        logic [`XLEN-1:0]  value;
        // branch outcome
        logic              taken;
        logic [`XLEN-1:0]  target;
    } rob_entry_t;

    // one broadcast on the common data bus
    typedef struct packed {
        logic              valid;
        // slot to mark done
        rob_tag_t          tag;
        logic [`XLEN-1:0]  value;
        logic              taken;
        logic [`XLEN-1:0]  target;
    } cdb_t;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // operations the back end can execute
    // ALU class first, branch class last
    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_slt,
        // compare a with b, target is pc + imm
        op_beq,
        op_bne
    } opcode_e;

    // architectural destination register, x0 to x31
    typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

/* common/rob_macros.svh */
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// reorder buffer slots, slot 0 included
// slot 0 is the "no tag" value, so one less is usable
`define ROB_ENTRIES 8

// tag width, enough to name every slot
`define ROB_TAG_W 3

// datapath width
`define XLEN 32

`endif
